// ==== Makefile ====
# Verilator build and run for the SID voice testbench.

TOP := tb_sid_voice
OBJ := obj_dir

.PHONY: all lint clean

# Build and run; the exit status of the simulation is the verdict.
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sid_voice.f
	./$(OBJ)/V$(TOP)

# Lint the design from its top level.
lint:
	verilator --lint-only --timing --top-module sid_voice -f sid_voice.f

clean:
	rm -rf $(OBJ)

// ==== sid_voice.f ====
+incdir+source
source/voice_regs_pkg.sv
source/waveform_pkg.sv
source/voice_apb_regs.sv
source/phase_accumulator.sv
source/waveform_generator.sv
source/sid_voice.sv
tb/tb_clock_gen.sv
tb/tb_sid_voice.sv

// ==== source/phase_accumulator.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

module phase_accumulator (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire voice_regs_pkg::freq_t     freq,
    input  wire logic                      test,
    output logic [`SID_ACC_WIDTH-1:0]      acc
);

    // Next phase.
    logic [`SID_ACC_WIDTH-1:0] acc_next;

    // ------------------------------------------------------------------------
    // Oscillator
    // ------------------------------------------------------------------------
    // Free-running phase, wraps at the accumulator width.
    // Test holds the phase at zero.
    always_comb begin
        if (test) begin
            acc_next = '0;
        end else begin
            acc_next = acc + freq;
        end
    end

    // Top bits give the sawtooth, bit 19 clocks the noise.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/sid_voice.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

module sid_voice (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           psel,
    input  wire logic                           penable,
    input  wire logic                           pwrite,
    input  wire logic [`SID_APB_ADDR_WIDTH-1:0] paddr,
    input  wire voice_regs_pkg::apb_word_t      pwdata,
    output voice_regs_pkg::apb_word_t           prdata,
    output logic                                pready,
    output waveform_pkg::sample_t               wav
);

    import voice_regs_pkg::*;
    import waveform_pkg::*;

    freq_t                     freq;
    pw_t                       pw;
    control_t                  ctrl;
    logic                      test;
    logic [`SID_ACC_WIDTH-1:0] acc;

    // Test bit also resets the oscillator.
    assign test = ctrl.test;

    // Register bank.
    voice_apb_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .freq    (freq),
        .pw      (pw),
        .ctrl    (ctrl)
    );

    // Oscillator.
    phase_accumulator u_osc (
        .clk    (clk),
        .arst_n (arst_n),
        .freq   (freq),
        .test   (test),
        .acc    (acc)
    );

    // Waveform generator, one register stage after the oscillator.
    waveform_generator u_wave (
        .clk    (clk),
        .arst_n (arst_n),
        .acc    (acc),
        .pw     (pw),
        .ctrl   (ctrl),
        .wav    (wav)
    );

endmodule

`default_nettype wire

// ==== source/sid_voice_defs.svh ====
`ifndef SID_VOICE_DEFS_SVH
`define SID_VOICE_DEFS_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------
// Phase accumulator width.
`define SID_ACC_WIDTH 24
// Pulse width, and also the sample width.
`define SID_PW_WIDTH 12
// Noise shift register width.
`define SID_LFSR_WIDTH 23

// ---------------------------------------------------------------------------
// APB register map
// ---------------------------------------------------------------------------
`define SID_APB_ADDR_WIDTH 4
`define SID_APB_DATA_WIDTH 32
// Byte addresses.
`define SID_ADDR_FREQ 4'h0
`define SID_ADDR_PW_CTRL 4'h4

// Accumulator bit whose rise clocks the noise LFSR.
`define SID_NOISE_TAP 19
// LFSR contents while test is held.
`define SID_LFSR_FILL {`SID_LFSR_WIDTH{1'b1}}

`endif

// ==== source/voice_apb_regs.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

module voice_apb_regs (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           psel,
    input  wire logic                           penable,
    input  wire logic                           pwrite,
    input  wire logic [`SID_APB_ADDR_WIDTH-1:0] paddr,
    input  wire voice_regs_pkg::apb_word_t      pwdata,
    output voice_regs_pkg::apb_word_t           prdata,
    output logic                                pready,
    output voice_regs_pkg::freq_t               freq,
    output voice_regs_pkg::pw_t                 pw,
    output waveform_pkg::control_t              ctrl
);

    import voice_regs_pkg::*;
    import waveform_pkg::*;

    logic        access;
    logic        wr_en;
    voice_word_u wr_word;
    voice_word_u rd_word;
    control_t    ctrl_wr;

    // Access phase of a transfer.
    assign access = psel & penable;
    assign wr_en  = access & pwrite;

    // No wait states.
    assign pready = 1'b1;

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------
    assign wr_word = pwdata;

    // Control byte with the unused low bits cleared.
    always_comb begin
        ctrl_wr          = wr_word.pw_ctrl_view.ctrl;
        ctrl_wr.reserved = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            freq <= '0;
            pw   <= '0;
            ctrl <= '0;
        end else if (wr_en) begin
            case (paddr)
                `SID_ADDR_FREQ: begin
                    freq <= wr_word.freq_view.freq;
                end
                `SID_ADDR_PW_CTRL: begin
                    pw   <= wr_word.pw_ctrl_view.pw;
                    ctrl <= ctrl_wr;
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    // Unmapped addresses and idle bus read as zero.
    always_comb begin
        rd_word = '0;
        if (access) begin
            case (paddr)
                `SID_ADDR_FREQ: begin
                    rd_word.freq_view.freq = freq;
                end
                `SID_ADDR_PW_CTRL: begin
                    rd_word.pw_ctrl_view.ctrl = ctrl;
                    rd_word.pw_ctrl_view.pw   = pw;
                end
                default: begin
                end
            endcase
        end
    end

    assign prdata = rd_word;

endmodule

`default_nettype wire

// ==== source/voice_regs_pkg.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

package voice_regs_pkg;

    // One APB data word.
    typedef logic [`SID_APB_DATA_WIDTH-1:0] apb_word_t;

    // Oscillator frequency, added to the accumulator every clock.
    typedef logic [`SID_ACC_WIDTH-1:0] freq_t;

    // Pulse width, compared against the top accumulator bits.
    typedef logic [`SID_PW_WIDTH-1:0] pw_t;

    // Word at the frequency address.
    typedef struct packed {
        logic [7:0] reserved;
        freq_t      freq;
    } freq_view_t;

    // Word at the pulse-width/control address.
    // The control byte keeps the SID bit order.
    typedef struct packed {
        logic [7:0] reserved_hi;
        logic [7:0] ctrl;
        logic [3:0] reserved_lo;
        pw_t        pw;
    } pw_ctrl_view_t;

    // Same bus word, decoded by address.
    typedef union packed {
        freq_view_t    freq_view;
        pw_ctrl_view_t pw_ctrl_view;
    } voice_word_u;

endpackage

`default_nettype wire

// ==== source/waveform_generator.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

module waveform_generator (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic [`SID_ACC_WIDTH-1:0] acc,
    input  wire voice_regs_pkg::pw_t       pw,
    input  wire waveform_pkg::control_t    ctrl,
    output waveform_pkg::sample_t          wav
);

    import waveform_pkg::*;

    // Lowest accumulator bit of the 12 used for the waveforms.
    localparam int TOP_LSB = `SID_ACC_WIDTH - `SID_PW_WIDTH;

    logic [`SID_PW_WIDTH-1:0]   acc_top;
    logic                       tap_prev;
    logic                       tap_rise;
    logic [`SID_LFSR_WIDTH-1:0] lfsr;
    logic                       pulse_on;
    sample_t                    noise_wav;
    sample_t                    pulse_wav;
    sample_t                    saw_wav;
    logic [`SID_PW_WIDTH-2:0]   tri_fold;
    sample_t                    tri_wav;
    wave_sel_t                  sel;
    sample_t                    wav_next;

    assign acc_top = acc[`SID_ACC_WIDTH-1:TOP_LSB];

    // ------------------------------------------------------------------------
    // Noise
    // ------------------------------------------------------------------------
    // Tap bit one edge back feeds the rise detection.
    assign tap_rise = ~tap_prev & acc[`SID_NOISE_TAP];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tap_prev <= 1'b0;
        end else begin
            tap_prev <= acc[`SID_NOISE_TAP];
        end
    end

    // Filled with ones while test is held.
    // Otherwise one shift per tap rise with feedback from bits 22 and 17.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= `SID_LFSR_FILL;
        end else if (ctrl.test) begin
            lfsr <= `SID_LFSR_FILL;
        end else if (tap_rise) begin
            lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
        end
    end

    // Eight scattered LFSR bits form the upper byte.
    assign noise_wav = {lfsr[20], lfsr[18], lfsr[14], lfsr[11],
                        lfsr[9], lfsr[5], lfsr[2], lfsr[0], 4'b0000};

    // ------------------------------------------------------------------------
    // Pulse, sawtooth and triangle
    // ------------------------------------------------------------------------
    // Test forces the pulse high.
    assign pulse_on  = (acc_top >= pw) | ctrl.test;
    assign pulse_wav = {`SID_PW_WIDTH{pulse_on}};

    assign saw_wav = acc_top;

    // Second half of the period counts back down.
    assign tri_fold = acc_top[10:0] ^ {11{acc_top[11]}};
    assign tri_wav  = {tri_fold, 1'b0};

    // ------------------------------------------------------------------------
    // Waveform select
    // ------------------------------------------------------------------------
    assign sel = {ctrl.noise, ctrl.pulse, ctrl.sawtooth, ctrl.triangle};

    // Combined waveforms are not modelled and give silence.
    always_comb begin
        case (sel)
            SEL_NOISE: wav_next = noise_wav;
            SEL_PULSE: wav_next = pulse_wav;
            SEL_SAW:   wav_next = saw_wav;
            SEL_TRI:   wav_next = tri_wav;
            SEL_NONE:  wav_next = '0;
            default:   wav_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wav <= '0;
        end else begin
            wav <= wav_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/waveform_pkg.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

package waveform_pkg;

    // Voice control byte, MSB first as on the SID.
    // The three low bits (ring, sync, gate there) are not kept.
    typedef struct packed {
        logic       noise;
        logic       pulse;
        logic       sawtooth;
        logic       triangle;
        logic       test;
        logic [2:0] reserved;
    } control_t;

    // Waveform select code in the order noise, pulse, saw, triangle.
    typedef logic [3:0] wave_sel_t;

    localparam wave_sel_t SEL_NOISE = 4'b1000;
    localparam wave_sel_t SEL_PULSE = 4'b0100;
    localparam wave_sel_t SEL_SAW   = 4'b0010;
    localparam wave_sel_t SEL_TRI   = 4'b0001;
    localparam wave_sel_t SEL_NONE  = 4'b0000;

    // Output sample of the waveform generator.
    typedef logic [`SID_PW_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    // Free-running clock.
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held low, released just after the last reset edge.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/tb_sid_voice.sv ====
`default_nettype none

`include "sid_voice_defs.svh"

module tb_sid_voice;

    import voice_regs_pkg::*;
    import waveform_pkg::*;

    // ------------------------------------------------------------------------
    // Run length, in clock cycles
    // ------------------------------------------------------------------------
    localparam int REG_ROUNDS    = 8;
    localparam int RUN_CYCLES    = 256;
    localparam int PW_ROUNDS     = 4;
    localparam int NOISE_CYCLES  = 512;
    localparam int COMBO_CYCLES  = 16;
    localparam int MAX_XFERS     = 100;
    localparam int TEST_CYCLES   = 10 + 2 * MAX_XFERS + RUN_CYCLES * (2 + PW_ROUNDS)
                                   + 16 + NOISE_CYCLES + 16 * COMBO_CYCLES;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + MARGIN_CYCLES) * 10;

    logic                           clk;
    logic                           arst_n;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`SID_APB_ADDR_WIDTH-1:0] paddr;
    apb_word_t                      pwdata;
    apb_word_t                      prdata;
    logic                           pready;
    sample_t                        wav;
    integer                         seed = 68;

    // Reference model state.
    freq_t                      m_freq;
    pw_t                        m_pw;
    control_t                   m_ctrl;
    logic [`SID_ACC_WIDTH-1:0]  m_acc;
    logic [`SID_LFSR_WIDTH-1:0] m_lfsr;
    logic                       m_tap_prev;
    sample_t                    exp_wav;
    voice_word_u                wr_view;
    voice_word_u                exp_rd_word;
    apb_word_t                  exp_prdata;

    tb_clock_gen clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    sid_voice dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .wav     (wav)
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Control byte from a select code and the test bit.
    function automatic control_t make_ctrl(input wave_sel_t s, input logic test);
        return control_t'({s, test, 3'b000});
    endfunction

    // Sample the voice should produce from one model state.
    function automatic sample_t expected_sample(input control_t c,
                                                input logic [`SID_ACC_WIDTH-1:0] a,
                                                input pw_t p,
                                                input logic [`SID_LFSR_WIDTH-1:0] l);
        logic [11:0] top;
        logic [11:0] fold;
        wave_sel_t   sel;
        top = a[`SID_ACC_WIDTH-1 -: 12];
        sel = {c.noise, c.pulse, c.sawtooth, c.triangle};
        if ($countones(sel) != 1) begin
            return '0;
        end else if (c.noise) begin
            return {l[20], l[18], l[14], l[11], l[9], l[5], l[2], l[0], 4'h0};
        end else if (c.pulse) begin
            return (top >= p || c.test) ? 12'hFFF : 12'h000;
        end else if (c.sawtooth) begin
            return top;
        end
        // Triangle folds down in the upper half, then doubles.
        fold = top[11] ? (top ^ 12'h7FF) : top;
        return {fold[10:0], 1'b0};
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    assign wr_view = pwdata;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_freq     <= '0;
            m_pw       <= '0;
            m_ctrl     <= '0;
            m_acc      <= '0;
            m_lfsr     <= '1;
            m_tap_prev <= 1'b0;
            exp_wav    <= '0;
        end else begin
            exp_wav    <= expected_sample(m_ctrl, m_acc, m_pw, m_lfsr);
            m_tap_prev <= m_acc[`SID_NOISE_TAP];
            m_acc      <= m_ctrl.test ? '0 : m_acc + m_freq;
            if (m_ctrl.test) begin
                m_lfsr <= '1;
            end else if (!m_tap_prev && m_acc[`SID_NOISE_TAP]) begin
                m_lfsr <= {m_lfsr[21:0], m_lfsr[22] ^ m_lfsr[17]};
            end
            // Register writes, as driven on the bus.
            if (psel && penable && pwrite) begin
                if (paddr == `SID_ADDR_FREQ) begin
                    m_freq <= wr_view.freq_view.freq;
                end else if (paddr == `SID_ADDR_PW_CTRL) begin
                    m_pw   <= wr_view.pw_ctrl_view.pw;
                    m_ctrl <= control_t'({wr_view.pw_ctrl_view.ctrl[7:3], 3'b000});
                end
            end
        end
    end

    // Read data expected in the access phase, zero otherwise.
    always_comb begin
        exp_rd_word = '0;
        if (psel && penable) begin
            if (paddr == `SID_ADDR_FREQ) begin
                exp_rd_word.freq_view.freq = m_freq;
            end else if (paddr == `SID_ADDR_PW_CTRL) begin
                exp_rd_word.pw_ctrl_view.ctrl = m_ctrl;
                exp_rd_word.pw_ctrl_view.pw   = m_pw;
            end
        end
        exp_prdata = exp_rd_word;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    wav_check: assert property (@(posedge clk) disable iff (!arst_n) wav == exp_wav)
        else stop_on_failure($sformatf("Error: wav = %h, expected %h",
                                       $sampled(wav), $sampled(exp_wav)));

    prdata_check: assert property (@(posedge clk) disable iff (!arst_n) prdata == exp_prdata)
        else stop_on_failure($sformatf("Error: prdata = %h, expected %h",
                                       $sampled(prdata), $sampled(exp_prdata)));

    pready_check: assert property (@(posedge clk) disable iff (!arst_n) pready == 1'b1)
        else stop_on_failure($sformatf("Error: pready = %h, expected %h",
                                       $sampled(pready), 1'b1));

    // ------------------------------------------------------------------------
    // APB driver
    // ------------------------------------------------------------------------
    // Entered and left one time unit after a rising edge.
    task automatic apb_transfer(input logic wr, input logic [3:0] addr, input apb_word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr);
        apb_transfer(1'b0, addr, pwdata);
    endtask

    task automatic write_freq(input freq_t f);
        voice_word_u w;
        w = '0;
        w.freq_view.freq = f;
        apb_transfer(1'b1, `SID_ADDR_FREQ, w);
    endtask

    task automatic write_pw_ctrl(input pw_t p, input control_t c);
        voice_word_u w;
        w = '0;
        w.pw_ctrl_view.ctrl = c;
        w.pw_ctrl_view.pw   = p;
        apb_transfer(1'b1, `SID_ADDR_PW_CTRL, w);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Ends a run that stops making progress.
    initial begin
        #(WATCHDOG_TIME);
        stop_on_failure("Watchdog timeout, the test sequence did not finish in time");
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        wait (arst_n);

        // Register readback, raw words with random reserved bits.
        for (int round = 0; round < REG_ROUNDS; round++) begin
            apb_transfer(1'b1, `SID_ADDR_FREQ, $random(seed));
            apb_transfer(1'b1, `SID_ADDR_PW_CTRL, $random(seed));
            apb_read(`SID_ADDR_FREQ);
            apb_read(`SID_ADDR_PW_CTRL);
            apb_read(4'(2 * round + 1));
            apb_read(4'h8);
        end

        // Sawtooth from a cleared oscillator.
        write_pw_ctrl('0, make_ctrl(SEL_SAW, 1'b1));
        write_freq(24'($random(seed)));
        write_pw_ctrl('0, make_ctrl(SEL_SAW, 1'b0));
        idle_cycles(RUN_CYCLES);

        // Triangle.
        write_pw_ctrl('0, make_ctrl(SEL_TRI, 1'b0));
        idle_cycles(RUN_CYCLES);

        // Pulse at several widths.
        for (int round = 0; round < PW_ROUNDS; round++) begin
            write_freq(24'($random(seed)));
            write_pw_ctrl(12'($random(seed)), make_ctrl(SEL_PULSE, 1'b0));
            idle_cycles(RUN_CYCLES);
        end
        // Widest pulse, held high by test.
        write_pw_ctrl(12'hFFF, make_ctrl(SEL_PULSE, 1'b1));
        idle_cycles(16);

        // Noise, refilled first, tap rising every few cycles.
        write_pw_ctrl('0, make_ctrl(SEL_NOISE, 1'b1));
        write_freq(24'h040000 | (24'($random(seed)) & 24'h03FFFF));
        idle_cycles(4);
        write_pw_ctrl('0, make_ctrl(SEL_NOISE, 1'b0));
        idle_cycles(NOISE_CYCLES);

        // No waveform, and every combination of two or more.
        for (int s = 0; s < 16; s++) begin
            if ($countones(4'(s)) != 1) begin
                write_pw_ctrl(12'($random(seed)), make_ctrl(4'(s), 1'b0));
                idle_cycles(COMBO_CYCLES);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
